// File: i2s_deci_regs.f
rtl/i2s_deci_pkg.sv
rtl/wb_slave_ack.sv
rtl/deci_fifo_reader.sv
rtl/i2s_ctrl_regs.sv
rtl/i2s_irq_regs.sv
rtl/reg_read_mux.sv
rtl/i2s_deci_regs.sv
tests/tb_i2s_deci_regs.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_i2s_deci_regs
FILELIST  = i2s_deci_regs.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: tests/tb_i2s_deci_regs.sv
`timescale 1ns/1ps

module tb_i2s_deci_regs;
	import i2s_deci_pkg::*;

	localparam int FIFO_DEPTH = 256;
	localparam int BUS_TIMEOUT = 20;

	logic WBs_CLK_i, WBs_RST_i;
	logic wbs_cyc_i, wbs_stb_i, wbs_we_i;
	logic [2:0] wbs_byte_stb_i;
	logic [ADDR_W-1:0] wbs_adr_i;
	logic [DATA_W-1:0] wbs_dat_i, wbs_dat_o;
	logic wbs_ack_o;
	sample_t fifo_dat_i;
	logic fifo_full_i, fifo_empty_i, fifo_pop_o, fifo_flush_o;
	level_t fifo_level_i, dma_cntr_i, dma_cnt_o;
	logic i2s_dis_i, deci_done_i, dma_done_i, dma_clr_i;
	logic dma_busy_i, dma_active_i, dma_req_i;
	logic [1:0] dma_st_i;
	logic i2s_en_o, fir_ena_o, dma_start_o;
	irq_vec_t irq_sts_o, irq_en_o;

	// fifo model and expected register state
	sample_t fifo_q[$];
	logic pop_seen;
	int n_pops, n_flush;
	level_t exp_thr;
	logic exp_dma_en;

	i2s_deci_regs #(.DMA_CNT_RST(DMA_CNT_RST)) uut (.*);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else abort_run($sformatf("Mismatch at %0t: %s got 0x%08h expected 0x%08h",
			$time, name, got, exp));
	endtask

	// ----------------------------------------------------------------------
	// clock, fifo model, event counters
	// ----------------------------------------------------------------------
	initial
	begin
		WBs_CLK_i = 1'b0;
		forever #10 WBs_CLK_i = ~WBs_CLK_i;
	end

	// pops sampled mid cycle and applied on the edge the DUT captures
	always @(negedge WBs_CLK_i)
	begin
		pop_seen = fifo_pop_o;
		if (fifo_pop_o)
			n_pops++;
		if (fifo_flush_o)
			n_flush++;
	end

	always @(posedge WBs_CLK_i)
	begin
		if (pop_seen && fifo_q.size() > 0)
			void'(fifo_q.pop_front());
		fifo_dat_i   <= (fifo_q.size() > 0) ? fifo_q[0] : 16'h0;
		fifo_empty_i <= (fifo_q.size() == 0);
		fifo_full_i  <= (fifo_q.size() >= FIFO_DEPTH);
		fifo_level_i <= 9'(fifo_q.size());
	end

	// ----------------------------------------------------------------------
	// protocol rules
	// ----------------------------------------------------------------------
	ack_width: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |=> !wbs_ack_o)
		else abort_run("acknowledge stayed high for more than one cycle");
	pop_empty: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		fifo_pop_o |-> !fifo_empty_i)
		else abort_run("pop issued while the FIFO was empty");
	flush_width: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		fifo_flush_o |=> !fifo_flush_o)
		else abort_run("flush pulse longer than one cycle");
	dma_req: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		dma_start_o == ((fifo_level_i >= exp_thr) && exp_dma_en))
		else abort_run("dma_start_o does not follow level, threshold and enable");

	// ----------------------------------------------------------------------
	// bus and stimulus tasks
	// ----------------------------------------------------------------------
	task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [31:0] wdat, input logic [2:0] bstb, output logic [31:0] rdat);
		int waited;
		logic got;
		waited = 0;
		got = 1'b0;
		rdat = '0;
		@(posedge WBs_CLK_i);
		wbs_cyc_i <= 1'b1;
		wbs_stb_i <= 1'b1;
		wbs_we_i <= we;
		wbs_adr_i <= adr;
		wbs_dat_i <= wdat;
		wbs_byte_stb_i <= bstb;
		while (!got)
		begin
			@(negedge WBs_CLK_i);
			if (wbs_ack_o)
			begin
				got = 1'b1;
				rdat = wbs_dat_o;
			end
			else
			begin
				waited++;
				if (waited > BUS_TIMEOUT)
					abort_run("bus acknowledge did not arrive");
			end
		end
		// shadow copy for the dma request rule
		if (we && bstb[0] && adr == DMA_EN_ADR)
			exp_dma_en = wdat[0];
		if (we && bstb[0] && adr == DMA_CNT_ADR)
			exp_thr = wdat[LEVEL_W-1:0];
		@(posedge WBs_CLK_i);
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
		wbs_we_i <= 1'b0;
	endtask

	task automatic reg_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_access(1'b1, adr, dat, 3'b111, unused);
	endtask

	task automatic read_expect(input logic [ADDR_W-1:0] adr, input logic [31:0] exp);
		logic [31:0] rd;
		bus_access(1'b0, adr, 32'h0, 3'b111, rd);
		check_value($sformatf("wbs_dat_o @0x%0h", adr), rd, exp);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge WBs_CLK_i);
	endtask

	task automatic push_word(input sample_t w);
		@(negedge WBs_CLK_i);
		fifo_q.push_back(w);
	endtask

	initial
	begin
		logic [31:0] r;
		logic en_bit;
		sample_t w0, w1, w2;
		int pops_before, flush_before;
		void'($urandom(32'hd2e62bbb));
		WBs_RST_i <= 1'b1;
		{wbs_cyc_i, wbs_stb_i, wbs_we_i} <= 3'b000;
		wbs_byte_stb_i <= 3'b000;
		wbs_adr_i <= '0;
		wbs_dat_i <= '0;
		{i2s_dis_i, deci_done_i, dma_done_i, dma_clr_i} <= 4'b0000;
		{dma_busy_i, dma_active_i, dma_req_i} <= 3'b000;
		dma_cntr_i <= '0;
		dma_st_i <= '0;
		fifo_dat_i <= '0;
		{fifo_full_i, fifo_empty_i} <= 2'b01;
		fifo_level_i <= '0;
		pop_seen = 1'b0;
		n_pops = 0;
		n_flush = 0;
		exp_thr = 9'd4;
		exp_dma_en = 1'b0;

		// reset values checked while reset is still held
		repeat (2) @(posedge WBs_CLK_i);
		@(negedge WBs_CLK_i);
		check_value("reset outputs", 32'({wbs_ack_o, fifo_pop_o, fifo_flush_o, i2s_en_o,
			fir_ena_o, dma_start_o, irq_sts_o, irq_en_o}), 32'h0);
		check_value("dma_cnt_o", 32'(dma_cnt_o), 32'd4);
		@(posedge WBs_CLK_i);
		WBs_RST_i <= 1'b0;
		read_expect(DMA_CNT_ADR, 32'd4);
		read_expect(I2S_EN_ADR, 32'h0);
		// connect flag sets as soon as disconnect is low
		read_expect(INTR_STS_ADR, 32'(1 << IRQ_I2S_CON));
		read_expect(INTR_EN_ADR, 32'h0);
		read_expect(FIFO_STS_ADR, 32'h0001_0000);
		read_expect(FIFO_RST_ADR, 32'h0);
		read_expect(DMA_EN_ADR, 32'h0);
		read_expect(DMA_STS_ADR, 32'h0);
		read_expect(FIR_CTRL_ADR, 32'h0);
		read_expect(10'h006, 32'h0);

		// random writes read back masked
		r = $urandom;
		en_bit = r[0];
		reg_write(I2S_EN_ADR, r);
		read_expect(I2S_EN_ADR, r & 32'h1);
		check_value("i2s_en_o", 32'(i2s_en_o), 32'(r[0]));
		r = $urandom;
		reg_write(FIR_CTRL_ADR, r);
		read_expect(FIR_CTRL_ADR, r & 32'h3);
		check_value("fir_ena_o", 32'(fir_ena_o), 32'(r[0]));
		reg_write(DMA_EN_ADR, $urandom);
		read_expect(DMA_EN_ADR, 32'(exp_dma_en));
		r = $urandom;
		reg_write(DMA_CNT_ADR, r);
		read_expect(DMA_CNT_ADR, r & 32'h1FF);
		check_value("dma_cnt_o", 32'(dma_cnt_o), r & 32'h1FF);
		r = $urandom;
		reg_write(INTR_EN_ADR, r);
		read_expect(INTR_EN_ADR, r & 32'h2F);
		check_value("irq_en_o", 32'(irq_en_o), r & 32'h2F);
		// lane 0 strobe clear leaves the register alone
		bus_access(1'b1, I2S_EN_ADR, {31'h0, ~en_bit}, 3'b110, r);
		read_expect(I2S_EN_ADR, 32'(en_bit));
		check_value("i2s_en_o", 32'(i2s_en_o), 32'(en_bit));
		flush_before = n_flush;
		reg_write(FIFO_RST_ADR, 32'h1);
		wait_cycles(2);
		check_value("flush pulses", 32'(n_flush - flush_before), 32'd1);
		read_expect(FIFO_RST_ADR, 32'h0);
		reg_write(DMA_CNT_ADR, 32'd4);
		reg_write(DMA_EN_ADR, 32'h0);

		// sticky flags
		@(posedge WBs_CLK_i) dma_done_i <= 1'b1;
		@(posedge WBs_CLK_i) dma_done_i <= 1'b0;
		@(posedge WBs_CLK_i) deci_done_i <= 1'b1;
		@(posedge WBs_CLK_i) deci_done_i <= 1'b0;
		wait_cycles(1);
		check_value("irq_sts_o", 32'(irq_sts_o), 32'h23);
		read_expect(INTR_STS_ADR, 32'h23);
		reg_write(INTR_STS_ADR, 32'h0);
		read_expect(INTR_STS_ADR, 32'(1 << IRQ_I2S_CON));
		// event on the same edge as the clearing write
		fork
			reg_write(INTR_STS_ADR, 32'h0);
			begin
				@(posedge WBs_CLK_i) dma_done_i <= 1'b1;
				@(posedge WBs_CLK_i) dma_done_i <= 1'b0;
			end
		join
		read_expect(INTR_STS_ADR, 32'h21);

		// disconnect and connect
		reg_write(I2S_EN_ADR, 32'h1);
		@(posedge WBs_CLK_i) i2s_dis_i <= 1'b1;
		wait_cycles(2);
		check_value("i2s_en_o", 32'(i2s_en_o), 32'h0);
		check_value("irq_sts_o dis", 32'(irq_sts_o[IRQ_I2S_DIS]), 32'h1);
		reg_write(INTR_STS_ADR, 32'h0);
		read_expect(INTR_STS_ADR, 32'(1 << IRQ_I2S_DIS));
		@(posedge WBs_CLK_i) i2s_dis_i <= 1'b0;
		reg_write(INTR_STS_ADR, 32'h0);
		read_expect(INTR_STS_ADR, 32'(1 << IRQ_I2S_CON));

		// fifo data read packs two words
		w0 = 16'($urandom);
		w1 = 16'($urandom);
		w2 = 16'($urandom);
		push_word(w0);
		push_word(w1);
		push_word(w2);
		read_expect(FIFO_STS_ADR, 32'd3);
		pops_before = n_pops;
		read_expect(FIFO_DAT_ADR, {w1, w0});
		check_value("pop count", 32'(n_pops - pops_before), 32'd2);
		read_expect(FIFO_STS_ADR, 32'd1);
		// fifo runs dry after one pop
		pops_before = n_pops;
		read_expect(FIFO_DAT_ADR, {w2, w1});
		check_value("pop count", 32'(n_pops - pops_before), 32'd1);
		read_expect(FIFO_STS_ADR, 32'h0001_0000);

		// dma request at threshold
		reg_write(DMA_EN_ADR, 32'h1);
		repeat (4) push_word(16'($urandom));
		wait_cycles(2);
		check_value("dma_start_o", 32'(dma_start_o), 32'h1);
		read_expect(INTR_STS_ADR, 32'(1 << IRQ_I2S_CON | 1 << IRQ_DAT_AVL));
		read_expect(DMA_STS_ADR, 32'h0000_8000);
		@(posedge WBs_CLK_i) dma_clr_i <= 1'b1;
		@(posedge WBs_CLK_i) dma_clr_i <= 1'b0;
		@(negedge WBs_CLK_i) exp_dma_en = 1'b0;
		check_value("dma_start_o", 32'(dma_start_o), 32'h0);
		read_expect(DMA_EN_ADR, 32'h0);
		@(posedge WBs_CLK_i);
		dma_done_i <= 1'b1;
		dma_busy_i <= 1'b1;
		dma_req_i <= 1'b1;
		dma_cntr_i <= 9'($urandom);
		dma_st_i <= 2'b10;
		@(posedge WBs_CLK_i) dma_done_i <= 1'b0;
		read_expect(DMA_STS_ADR, {2'b10, 5'h0, dma_cntr_i, 1'b0, 11'h0, 4'b1011});
		// active bit on its own, busy dropped
		@(posedge WBs_CLK_i);
		dma_active_i <= 1'b1;
		dma_busy_i <= 1'b0;
		dma_st_i <= 2'b01;
		read_expect(DMA_STS_ADR, {2'b01, 5'h0, dma_cntr_i, 1'b0, 11'h0, 4'b1110});

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: rtl/i2s_deci_regs.sv
`timescale 1ns/1ps

module i2s_deci_regs #(
	parameter i2s_deci_pkg::level_t DMA_CNT_RST = i2s_deci_pkg::DMA_CNT_RST
) (
	input  logic                            WBs_CLK_i,
	input  logic                            WBs_RST_i,
	// slave bus
	input  logic                            wbs_cyc_i,
	input  logic                            wbs_stb_i,
	input  logic                            wbs_we_i,
	input  logic [2:0]                      wbs_byte_stb_i,
	input  logic [i2s_deci_pkg::ADDR_W-1:0] wbs_adr_i,
	input  logic [i2s_deci_pkg::DATA_W-1:0] wbs_dat_i,
	output logic [i2s_deci_pkg::DATA_W-1:0] wbs_dat_o,
	output logic                            wbs_ack_o,
	// decimated data fifo
	input  i2s_deci_pkg::sample_t           fifo_dat_i,
	input  logic                            fifo_full_i,
	input  logic                            fifo_empty_i,
	input  i2s_deci_pkg::level_t            fifo_level_i,
	output logic                            fifo_pop_o,
	output logic                            fifo_flush_o,
	// i2s and fir status
	input  logic                            i2s_dis_i,
	input  logic                            deci_done_i,
	// dma engine
	input  logic                            dma_done_i,
	input  logic                            dma_clr_i,
	input  logic                            dma_busy_i,
	input  logic                            dma_active_i,
	input  logic                            dma_req_i,
	input  i2s_deci_pkg::level_t            dma_cntr_i,
	input  logic [1:0]                      dma_st_i,
	// control and interrupt outputs
	output logic                            i2s_en_o,
	output logic                            fir_ena_o,
	output logic                            dma_start_o,
	output i2s_deci_pkg::level_t            dma_cnt_o,
	output i2s_deci_pkg::irq_vec_t          irq_sts_o,
	output i2s_deci_pkg::irq_vec_t          irq_en_o
);
	import i2s_deci_pkg::*;

	logic              wr_en;
	logic              fifo_rd;
	logic [DATA_W-1:0] fifo_word;
	logic              fir_int_en;
	logic              dma_en;
	logic              dat_avl;

	// bus ack, write strobe and fifo read window
	wb_slave_ack u_ack (
		.WBs_CLK_i, .WBs_RST_i, .wbs_cyc_i, .wbs_stb_i, .wbs_we_i,
		.wbs_byte_stb_i, .wbs_adr_i,
		.ack_o(wbs_ack_o), .wr_en_o(wr_en), .fifo_rd_o(fifo_rd)
	);

	deci_fifo_reader u_fifo_rd (
		.WBs_CLK_i, .WBs_RST_i, .fifo_rd_i(fifo_rd), .fifo_empty_i, .fifo_dat_i,
		.fifo_pop_o, .fifo_word_o(fifo_word)
	);

	i2s_ctrl_regs #(.DMA_CNT_RST(DMA_CNT_RST)) u_ctrl (
		.WBs_CLK_i, .WBs_RST_i, .wr_en_i(wr_en), .wbs_adr_i, .wbs_dat_i,
		.fifo_level_i, .i2s_dis_i, .dma_clr_i,
		.i2s_en_o, .fir_ena_o, .fir_int_en_o(fir_int_en), .fifo_flush_o,
		.dma_en_o(dma_en), .dma_cnt_o, .dma_start_o, .dat_avl_o(dat_avl)
	);

	i2s_irq_regs u_irq (
		.WBs_CLK_i, .WBs_RST_i, .wr_en_i(wr_en), .wbs_adr_i, .wbs_dat_i,
		.dma_done_i, .deci_done_i, .i2s_dis_i, .dat_avl_i(dat_avl),
		.irq_sts_o, .irq_en_o
	);

	reg_read_mux u_rd_mux (
		.wbs_adr_i, .i2s_en_i(i2s_en_o), .fir_ena_i(fir_ena_o),
		.fir_int_en_i(fir_int_en), .fifo_flush_i(fifo_flush_o), .dma_en_i(dma_en),
		.dma_cnt_i(dma_cnt_o), .dma_start_i(dma_start_o), .irq_sts_i(irq_sts_o),
		.irq_en_i(irq_en_o), .fifo_word_i(fifo_word), .fifo_full_i, .fifo_empty_i,
		.fifo_level_i, .dma_busy_i, .dma_active_i, .dma_req_i, .dma_cntr_i,
		.dma_st_i, .wbs_dat_o
	);

endmodule

// File: rtl/reg_read_mux.sv
`timescale 1ns/1ps

module reg_read_mux (
	input  logic [i2s_deci_pkg::ADDR_W-1:0] wbs_adr_i,
	input  logic                            i2s_en_i,
	input  logic                            fir_ena_i,
	input  logic                            fir_int_en_i,
	input  logic                            fifo_flush_i,
	input  logic                            dma_en_i,
	input  i2s_deci_pkg::level_t            dma_cnt_i,
	input  logic                            dma_start_i,
	input  i2s_deci_pkg::irq_vec_t          irq_sts_i,
	input  i2s_deci_pkg::irq_vec_t          irq_en_i,
	input  logic [i2s_deci_pkg::DATA_W-1:0] fifo_word_i,
	input  logic                            fifo_full_i,
	input  logic                            fifo_empty_i,
	input  i2s_deci_pkg::level_t            fifo_level_i,
	input  logic                            dma_busy_i,
	input  logic                            dma_active_i,
	input  logic                            dma_req_i,
	input  i2s_deci_pkg::level_t            dma_cntr_i,
	input  logic [1:0]                      dma_st_i,
	output logic [i2s_deci_pkg::DATA_W-1:0] wbs_dat_o
);
	import i2s_deci_pkg::*;

	logic [DATA_W-1:0] fifo_sts;
	logic [DATA_W-1:0] dma_sts;

	// full at 17, empty at 16, level in the low bits
	assign fifo_sts = {14'h0, fifo_full_i, fifo_empty_i, 7'h0, fifo_level_i};

	// state on top, counter in the middle, strobes at the bottom
	// done bit shares the sticky dma done flag
	assign dma_sts = {dma_st_i, 5'h0, dma_cntr_i, dma_start_i, 11'h0,
		dma_req_i, dma_active_i, irq_sts_i[IRQ_DMA_DONE], dma_busy_i};

	// ------------------------------------------------------------------
	// read data select
	// ------------------------------------------------------------------
	always_comb
	begin
		case (wbs_adr_i)
			I2S_EN_ADR:   wbs_dat_o = DATA_W'(i2s_en_i);
			INTR_STS_ADR: wbs_dat_o = DATA_W'(irq_sts_i);
			INTR_EN_ADR:  wbs_dat_o = DATA_W'(irq_en_i);
			FIFO_STS_ADR: wbs_dat_o = fifo_sts;
			// packed word is valid by the delayed ack
			FIFO_DAT_ADR: wbs_dat_o = fifo_word_i;
			FIFO_RST_ADR: wbs_dat_o = DATA_W'(fifo_flush_i);
			DMA_EN_ADR:   wbs_dat_o = DATA_W'(dma_en_i);
			DMA_STS_ADR:  wbs_dat_o = dma_sts;
			DMA_CNT_ADR:  wbs_dat_o = DATA_W'(dma_cnt_i);
			FIR_CTRL_ADR: wbs_dat_o = DATA_W'({fir_int_en_i, fir_ena_i});
			// holes in the map read zero
			default:      wbs_dat_o = '0;
		endcase
	end

endmodule

// File: rtl/i2s_irq_regs.sv
`timescale 1ns/1ps

module i2s_irq_regs (
	input  logic                            WBs_CLK_i,
	input  logic                            WBs_RST_i,
	input  logic                            wr_en_i,
	input  logic [i2s_deci_pkg::ADDR_W-1:0] wbs_adr_i,
	input  logic [i2s_deci_pkg::DATA_W-1:0] wbs_dat_i,
	input  logic                            dma_done_i,
	input  logic                            deci_done_i,
	input  logic                            i2s_dis_i,
	input  logic                            dat_avl_i,
	output i2s_deci_pkg::irq_vec_t          irq_sts_o,
	output i2s_deci_pkg::irq_vec_t          irq_en_o
);
	import i2s_deci_pkg::*;

	// flags that hold until the host writes them
	localparam irq_vec_t STICKY_MASK = irq_vec_t'((1 << IRQ_DMA_DONE) |
		(1 << IRQ_DECI_DONE) | (1 << IRQ_I2S_DIS) | (1 << IRQ_I2S_CON));
	// every defined position, bit 4 excluded
	localparam irq_vec_t EN_MASK = STICKY_MASK | irq_vec_t'(1 << IRQ_DAT_AVL);

	logic     wr_sts;
	logic     wr_en_reg;
	irq_vec_t irq_evt;
	irq_vec_t irq_flags;

	assign wr_sts    = wr_en_i & (wbs_adr_i == INTR_STS_ADR);
	assign wr_en_reg = wr_en_i & (wbs_adr_i == INTR_EN_ADR);

	// ------------------------------------------------------------------
	// event vector
	// ------------------------------------------------------------------
	always_comb
	begin
		irq_evt                = '0;
		irq_evt[IRQ_DMA_DONE]  = dma_done_i;
		irq_evt[IRQ_DECI_DONE] = deci_done_i;
		irq_evt[IRQ_I2S_DIS]   = i2s_dis_i;
		// connect is simply the absence of disconnect
		irq_evt[IRQ_I2S_CON]   = ~i2s_dis_i;
	end

	// ------------------------------------------------------------------
	// sticky flags and enables
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			irq_flags <= '0;
			irq_en_o  <= '0;
		end
		else
		begin
			// event in the same cycle as a clearing write wins
			if (wr_sts)
				irq_flags <= (wbs_dat_i[IRQ_W-1:0] | irq_evt) & STICKY_MASK;
			else
				irq_flags <= (irq_flags | irq_evt) & STICKY_MASK;

			if (wr_en_reg)
				irq_en_o <= wbs_dat_i[IRQ_W-1:0] & EN_MASK;
		end
	end

	// data available is a live copy, writes do not touch it
	always_comb
	begin
		irq_sts_o              = irq_flags;
		irq_sts_o[IRQ_DAT_AVL] = dat_avl_i;
	end

endmodule

// File: rtl/i2s_ctrl_regs.sv
`timescale 1ns/1ps

module i2s_ctrl_regs #(
	parameter i2s_deci_pkg::level_t DMA_CNT_RST = i2s_deci_pkg::DMA_CNT_RST
) (
	input  logic                            WBs_CLK_i,
	input  logic                            WBs_RST_i,
	input  logic                            wr_en_i,
	input  logic [i2s_deci_pkg::ADDR_W-1:0] wbs_adr_i,
	input  logic [i2s_deci_pkg::DATA_W-1:0] wbs_dat_i,
	input  i2s_deci_pkg::level_t            fifo_level_i,
	input  logic                            i2s_dis_i,
	input  logic                            dma_clr_i,
	output logic                            i2s_en_o,
	output logic                            fir_ena_o,
	output logic                            fir_int_en_o,
	output logic                            fifo_flush_o,
	output logic                            dma_en_o,
	output i2s_deci_pkg::level_t            dma_cnt_o,
	output logic                            dma_start_o,
	output logic                            dat_avl_o
);
	import i2s_deci_pkg::*;

	// per register write decodes
	logic wr_i2s_en;
	logic wr_fir_ctrl;
	logic wr_fifo_rst;
	logic wr_dma_en;
	logic wr_dma_cnt;

	// write strobe is already qualified upstream
	assign wr_i2s_en   = wr_en_i & (wbs_adr_i == I2S_EN_ADR);
	assign wr_fir_ctrl = wr_en_i & (wbs_adr_i == FIR_CTRL_ADR);
	assign wr_fifo_rst = wr_en_i & (wbs_adr_i == FIFO_RST_ADR);
	assign wr_dma_en   = wr_en_i & (wbs_adr_i == DMA_EN_ADR);
	assign wr_dma_cnt  = wr_en_i & (wbs_adr_i == DMA_CNT_ADR);

	// ------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			i2s_en_o     <= 1'b0;
			fir_ena_o    <= 1'b0;
			fir_int_en_o <= 1'b0;
			fifo_flush_o <= 1'b0;
			dma_en_o     <= 1'b0;
			dma_cnt_o    <= DMA_CNT_RST;
		end
		else
		begin
			// host write beats the disconnect clear
			if (wr_i2s_en)
				i2s_en_o <= wbs_dat_i[0];
			else if (i2s_dis_i)
				i2s_en_o <= 1'b0;

			// fir enable in bit 0, its interrupt enable in bit 1
			if (wr_fir_ctrl)
			begin
				fir_ena_o    <= wbs_dat_i[0];
				fir_int_en_o <= wbs_dat_i[1];
			end

			// flush is a one cycle pulse, self clearing
			fifo_flush_o <= wr_fifo_rst & wbs_dat_i[0];

			// dma engine clears its own enable when a transfer ends
			if (wr_dma_en)
				dma_en_o <= wbs_dat_i[0];
			else if (dma_clr_i)
				dma_en_o <= 1'b0;

			if (wr_dma_cnt)
				dma_cnt_o <= wbs_dat_i[LEVEL_W-1:0];
		end
	end

	// ------------------------------------------------------------------
	// dma request
	// ------------------------------------------------------------------

	// enough words queued for one burst
	assign dat_avl_o   = (fifo_level_i >= dma_cnt_o);
	assign dma_start_o = dat_avl_o & dma_en_o;

endmodule

// File: rtl/deci_fifo_reader.sv
`timescale 1ns/1ps

module deci_fifo_reader (
	input  logic                            WBs_CLK_i,
	input  logic                            WBs_RST_i,
	input  logic                            fifo_rd_i,
	input  logic                            fifo_empty_i,
	input  i2s_deci_pkg::sample_t           fifo_dat_i,
	output logic                            fifo_pop_o,
	output logic [i2s_deci_pkg::DATA_W-1:0] fifo_word_o
);
	import i2s_deci_pkg::*;

	// two halves of the packed read word
	sample_t word_up;
	sample_t word_lo;
	logic    pop;

	// ------------------------------------------------------------------
	// pop generation
	// ------------------------------------------------------------------

	// empty fifo holds the reader off
	// bus ack still completes with the old words
	assign pop = fifo_rd_i & ~fifo_empty_i;

	assign fifo_pop_o = pop;

	// ------------------------------------------------------------------
	// packing shift register
	// ------------------------------------------------------------------

	// head word is captured on the same edge that pops it
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			word_up <= '0;
			word_lo <= '0;
		end
		else if (pop)
		begin
			// newest sample on top
			word_up <= fifo_dat_i;
			// previous top slides down
			word_lo <= word_up;
		end
	end

	// second popped word high, first low
	assign fifo_word_o = {word_up, word_lo};

endmodule

// File: rtl/wb_slave_ack.sv
`timescale 1ns/1ps

module wb_slave_ack (
	input  logic                            WBs_CLK_i,
	input  logic                            WBs_RST_i,
	input  logic                            wbs_cyc_i,
	input  logic                            wbs_stb_i,
	input  logic                            wbs_we_i,
	input  logic [2:0]                      wbs_byte_stb_i,
	input  logic [i2s_deci_pkg::ADDR_W-1:0] wbs_adr_i,
	output logic                            ack_o,
	output logic                            wr_en_o,
	output logic                            fifo_rd_o
);
	import i2s_deci_pkg::*;

	// request qualifiers
	logic bus_req;
	logic fifo_read;
	logic ack_nxt;
	// immediate and delayed acknowledge stages
	logic ack_imm;
	logic ack_dly;

	assign bus_req   = wbs_cyc_i & wbs_stb_i;
	// fifo data reads need one extra cycle for the second pop
	assign fifo_read = bus_req & ~wbs_we_i & (wbs_adr_i == FIFO_DAT_ADR);

	// new request only once both stages have dropped
	assign ack_nxt = bus_req & ~ack_imm & ~ack_dly;

	// ------------------------------------------------------------------
	// acknowledge pipeline
	// ------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			ack_imm <= 1'b0;
			ack_dly <= 1'b0;
		end
		else
		begin
			ack_imm <= ack_nxt;
			// delayed stage only follows a fifo data read
			// so a register ack never echoes into the next access
			ack_dly <= ack_imm & fifo_read;
		end
	end

	// stage select per access type
	assign ack_o = fifo_read ? ack_dly : ack_imm;

	// single write strobe for every register block
	// lands on the edge that raises the ack
	assign wr_en_o = ack_nxt & wbs_we_i & wbs_byte_stb_i[0];

	// pop window, closes when the delayed ack rises
	assign fifo_rd_o = fifo_read & ~ack_dly;

endmodule

// File: rtl/i2s_deci_pkg.sv
package i2s_deci_pkg;

	// ------------------------------------------------------------------
	// bus and datapath widths
	// ------------------------------------------------------------------

	// word address of the register window
	localparam int ADDR_W   = 10;
	localparam int DATA_W   = 32;
	// one decimated sample
	localparam int SAMPLE_W = 16;
	// fifo fill level, also the dma threshold
	localparam int LEVEL_W  = 9;

	typedef logic [LEVEL_W-1:0]  level_t;
	typedef logic [SAMPLE_W-1:0] sample_t;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------

	localparam logic [ADDR_W-1:0] I2S_EN_ADR   = 10'h000;
	// sticky flags, write to clear or set
	localparam logic [ADDR_W-1:0] INTR_STS_ADR = 10'h002;
	localparam logic [ADDR_W-1:0] INTR_EN_ADR  = 10'h003;
	localparam logic [ADDR_W-1:0] FIFO_STS_ADR = 10'h004;
	// read pops two samples
	localparam logic [ADDR_W-1:0] FIFO_DAT_ADR = 10'h005;
	localparam logic [ADDR_W-1:0] FIFO_RST_ADR = 10'h007;
	localparam logic [ADDR_W-1:0] DMA_EN_ADR   = 10'h008;
	// read only status word
	localparam logic [ADDR_W-1:0] DMA_STS_ADR  = 10'h009;
	localparam logic [ADDR_W-1:0] DMA_CNT_ADR  = 10'h00A;
	localparam logic [ADDR_W-1:0] FIR_CTRL_ADR = 10'h00C;

	// ------------------------------------------------------------------
	// interrupt vector layout
	// ------------------------------------------------------------------

	localparam int IRQ_DMA_DONE  = 0;
	localparam int IRQ_DECI_DONE = 1;
	// live level compare, not sticky
	localparam int IRQ_DAT_AVL   = 2;
	localparam int IRQ_I2S_DIS   = 3;
	// bit 4 reserved, reads zero
	localparam int IRQ_I2S_CON   = 5;

	localparam int IRQ_W = 6;

	typedef logic [IRQ_W-1:0] irq_vec_t;

	// dma threshold out of reset, in fifo words
	localparam level_t DMA_CNT_RST = 9'd4;

endpackage
